// File: pkg_tpu.sv
/*
 * TPU front-end shared definitions
 * Opcodes, the tagged instruction word, context widths and FSM encoding
 */
`default_nettype none

package pkg_tpu;

	////////////////////////////////////////////////////////////
	// Field widths
	////////////////////////////////////////////////////////////
	localparam int OPERAND_W	= 16;		// Immediate operand
	localparam int ID_W		= 8;		// Thread ID
	localparam int ISSUE_NO_W	= 4;		// MPU issue number
	localparam int ACC_W		= 32;		// Scalar accumulator

	////////////////////////////////////////////////////////////
	// Instruction word
	////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		OP_NOP	= 2'd0,
		OP_ADD	= 2'd1,
		OP_MUL	= 2'd2,
		OP_END	= 2'd3				// Closes the thread
	} op_t;

	// Header and thread-ID words only use v and operand
	typedef struct packed {
		logic				v;		// Word valid
		op_t				op;
		logic [OPERAND_W-1:0]	operand;	// Unsigned immediate
	} instr_t;

	typedef logic [ID_W-1:0]		id_t;
	typedef logic [ISSUE_NO_W-1:0]	issue_no_t;
	typedef logic [ACC_W-1:0]		acc_t;		// Wraps modulo 2^32

	////////////////////////////////////////////////////////////
	// Front-end FSM
	////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		FE_INIT		= 3'd0,		// Context cleared
		FE_SCALAR	= 3'd1,		// Waiting for header
		FE_SIMT		= 3'd2,		// Waiting for thread ID
		FE_INSTR	= 3'd3,		// Streaming instructions
		FE_WAIT_TERM	= 3'd4		// END sent, waiting for sequencer
	} fe_state_t;

endpackage

`default_nettype wire

// File: tpu_front_end.sv
/*
 * TPU instruction front end
 * Walks the host word stream, latches thread context and stamps instructions
 */
`timescale 1ns/10ps
`default_nettype none

module tpu_front_end (
	input wire				clock,
	input wire				reset,
	input wire				en_exe,		// Execution enable level
	input wire				req,		// Host request level
	input wire pkg_tpu::instr_t		word,
	input wire pkg_tpu::issue_no_t	issue_no,	// Taken with the header
	input wire				almost_full,	// From instruction buffer
	input wire				term,		// Thread end from sequencer
	output logic				nack,
	output logic				buf_we,
	output pkg_tpu::instr_t			buf_instr,
	output pkg_tpu::id_t			buf_thread_id,
	output pkg_tpu::issue_no_t		buf_issue_no
);

	pkg_tpu::fe_state_t		state;
	pkg_tpu::id_t			r_thread_id;
	pkg_tpu::issue_no_t		r_issue_no;
	logic				r_almost_full;
	logic				r_term;

	logic				accept;		// Word taken at this edge
	logic				is_header;
	logic				is_end;

	////////////////////////////////////////////////////////////
	// Handshake
	////////////////////////////////////////////////////////////
	assign accept		= req & en_exe & word.v & ~nack;
	assign is_header	= (state == pkg_tpu::FE_INIT) | (state == pkg_tpu::FE_SCALAR);
	assign is_end		= word.op == pkg_tpu::OP_END;

	// Registered sources only, so nack holds for the whole cycle
	assign nack		= r_almost_full | (state == pkg_tpu::FE_WAIT_TERM);

	assign buf_thread_id	= r_thread_id;		// Context stamp
	assign buf_issue_no	= r_issue_no;

	always_ff @(posedge clock) begin
		if (reset) begin
			r_almost_full	<= 1'b0;
			r_term		<= 1'b0;
		end else begin
			r_almost_full	<= almost_full;
			r_term		<= term;
		end
	end

	////////////////////////////////////////////////////////////
	// Stream FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= pkg_tpu::FE_INIT;
		end else begin
			case (state)
				pkg_tpu::FE_INIT: begin
					if (accept) begin
						state <= pkg_tpu::FE_SIMT;	// Header right away
					end else begin
						state <= pkg_tpu::FE_SCALAR;
					end
				end
				pkg_tpu::FE_SCALAR: begin
					if (accept) begin
						state <= pkg_tpu::FE_SIMT;
					end
				end
				pkg_tpu::FE_SIMT: begin
					if (accept) begin
						state <= pkg_tpu::FE_INSTR;
					end
				end
				pkg_tpu::FE_INSTR: begin
					if (accept && is_end) begin
						state <= pkg_tpu::FE_WAIT_TERM;
					end
				end
				pkg_tpu::FE_WAIT_TERM: begin
					if (r_term) begin
						state <= pkg_tpu::FE_INIT;
					end
				end
				default: begin
					state <= pkg_tpu::FE_INIT;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Thread context
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset || r_term) begin
			r_issue_no	<= '0;
			r_thread_id	<= '0;
		end else begin
			if (accept && is_header) begin
				r_issue_no	<= issue_no;
			end
			if (accept && state == pkg_tpu::FE_SIMT) begin
				r_thread_id	<= word.operand[pkg_tpu::ID_W-1:0];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Buffer write stage
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			buf_we <= 1'b0;
		end else begin
			buf_we <= accept & (state == pkg_tpu::FE_INSTR);
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			buf_instr <= word;		// Held for the write cycle
		end
	end

	// Writes trail the accepted instruction by exactly one cycle
	a_we_in_stream: assert property (@(posedge clock) disable iff (reset)
		buf_we |-> (state == pkg_tpu::FE_INSTR) ||
			(state == pkg_tpu::FE_WAIT_TERM && $past(state) == pkg_tpu::FE_INSTR))
		else $error("buffer write outside instruction phase");

endmodule

`default_nettype wire

// File: tpu_instr_buffer.sv
/*
 * Instruction buffer
 * Circular FIFO of stamped instructions with a look-ahead almost-full flag
 */
`timescale 1ns/10ps
`default_nettype none

module tpu_instr_buffer #(
	parameter int BUFFER_DEPTH = 8
) (
	input wire				clock,
	input wire				reset,
	input wire				we,
	input wire pkg_tpu::instr_t		wr_instr,
	input wire pkg_tpu::id_t		wr_thread_id,
	input wire pkg_tpu::issue_no_t	wr_issue_no,
	input wire				pop,
	output logic				empty,
	output logic				almost_full,
	output pkg_tpu::instr_t			rd_instr,	// Head entry
	output pkg_tpu::id_t			rd_thread_id,
	output pkg_tpu::issue_no_t		rd_issue_no
);

	localparam int PTR_W	= (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
	localparam int CNT_W	= $clog2(BUFFER_DEPTH + 1);
	localparam int OCC_W	= CNT_W + 1;

	pkg_tpu::instr_t		mem_instr [BUFFER_DEPTH];
	pkg_tpu::id_t			mem_thread_id [BUFFER_DEPTH];
	pkg_tpu::issue_no_t		mem_issue_no [BUFFER_DEPTH];

	logic [PTR_W-1:0]		wr_ptr;
	logic [PTR_W-1:0]		rd_ptr;
	logic [CNT_W-1:0]		count;
	logic [OCC_W-1:0]		occupancy;	// Count plus write on the port
	logic				full;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(BUFFER_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full		= count == CNT_W'(BUFFER_DEPTH);
	assign empty		= count == '0;
	assign occupancy	= {1'b0, count} + OCC_W'(we);
	assign almost_full	= occupancy >= OCC_W'(BUFFER_DEPTH - 1);	// Room for one in flight

	assign rd_instr		= mem_instr[rd_ptr];
	assign rd_thread_id	= mem_thread_id[rd_ptr];
	assign rd_issue_no	= mem_issue_no[rd_ptr];

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end else begin
			if (we) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({we, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;		// Idle or both
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (we) begin
			mem_instr[wr_ptr]	<= wr_instr;
			mem_thread_id[wr_ptr]	<= wr_thread_id;
			mem_issue_no[wr_ptr]	<= wr_issue_no;
		end
	end

	// Front-end nack must keep the writer off a full buffer
	a_no_overflow: assert property (@(posedge clock) disable iff (reset) we |-> !full)
		else $error("write into full instruction buffer");

	a_no_underflow: assert property (@(posedge clock) disable iff (reset) pop |-> !empty)
		else $error("pop from empty instruction buffer");

endmodule

`default_nettype wire

// File: tpu_scalar_sequencer.sv
/*
 * Scalar sequencer
 * Executes NOP, ADD and MUL on the accumulator and commits on END
 */
`timescale 1ns/10ps
`default_nettype none

module tpu_scalar_sequencer #(
	parameter int MUL_CYCLES = 4
) (
	input wire				clock,
	input wire				reset,
	input wire				empty,		// Buffer has no entry
	input wire pkg_tpu::instr_t		instr,		// Buffer head
	input wire pkg_tpu::id_t		thread_id,
	input wire pkg_tpu::issue_no_t	issue_no,
	output logic				pop,
	output logic				term,		// Thread end pulse
	output logic				commit_valid,
	output pkg_tpu::issue_no_t		commit_issue_no,
	output pkg_tpu::id_t			commit_thread_id,
	output pkg_tpu::acc_t			commit_acc
);

	localparam int CNT_W = $clog2(MUL_CYCLES + 1);

	pkg_tpu::acc_t			acc;
	pkg_tpu::acc_t			product;	// Accumulator times head operand
	pkg_tpu::acc_t			r_product;
	logic [CNT_W-1:0]		mul_cnt;	// Remaining MUL cycles
	logic				mul_busy;
	logic				is_mul;
	logic				is_end;

	assign mul_busy	= mul_cnt != '0;
	assign pop	= ~empty & ~mul_busy;
	assign is_mul	= instr.op == pkg_tpu::OP_MUL;
	assign is_end	= instr.op == pkg_tpu::OP_END;
	assign product	= acc * pkg_tpu::acc_t'(instr.operand);

	////////////////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			acc		<= '0;
			mul_cnt		<= '0;
			term		<= 1'b0;
			commit_valid	<= 1'b0;
		end else begin
			term		<= 1'b0;
			commit_valid	<= 1'b0;
			if (mul_busy) begin
				mul_cnt <= mul_cnt - 1'b1;
				if (mul_cnt == CNT_W'(1)) begin
					acc <= r_product;		// Last MUL cycle
				end
			end else if (pop) begin
				case (instr.op)
					pkg_tpu::OP_ADD: begin
						acc <= acc + pkg_tpu::acc_t'(instr.operand);
					end
					pkg_tpu::OP_MUL: begin
						if (MUL_CYCLES == 1) begin
							acc <= product;
						end else begin
							mul_cnt <= CNT_W'(MUL_CYCLES - 1);
						end
					end
					pkg_tpu::OP_END: begin
						term		<= 1'b1;
						commit_valid	<= 1'b1;
						acc		<= '0;		// Next thread starts clean
					end
					default: begin
						acc <= acc;			// NOP
					end
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Product and commit payload
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (pop && is_mul) begin
			r_product <= product;
		end
	end

	always_ff @(posedge clock) begin
		if (pop && is_end) begin
			commit_acc		<= acc;
			commit_thread_id	<= thread_id;
			commit_issue_no		<= issue_no;
		end
	end

	// A popped MUL keeps the buffer head in place on the following cycle
	a_mul_holds_pop: assert property (@(posedge clock) disable iff (reset)
		($past(pop && is_mul) && MUL_CYCLES > 1) |-> !pop)
		else $error("pop while MUL in progress");

endmodule

`default_nettype wire

// File: tpu_frontend_top.sv
/*
 * TPU front-end top level
 * Front end, instruction buffer and scalar sequencer for one thread lane
 */
`timescale 1ns/10ps
`default_nettype none

module tpu_frontend_top #(
	parameter int BUFFER_DEPTH	= 8,
	parameter int MUL_CYCLES	= 4
) (
	input wire				clock,
	input wire				reset,
	input wire				en_exe,
	input wire				req,
	input wire pkg_tpu::instr_t		word,
	input wire pkg_tpu::issue_no_t	issue_no,
	output logic				nack,
	output logic				commit_valid,
	output pkg_tpu::issue_no_t		commit_issue_no,
	output pkg_tpu::id_t			commit_thread_id,
	output pkg_tpu::acc_t			commit_acc
);

	// Front end to buffer
	logic				buf_we;
	pkg_tpu::instr_t		buf_instr;
	pkg_tpu::id_t			buf_thread_id;
	pkg_tpu::issue_no_t		buf_issue_no;
	logic				almost_full;

	// Buffer to sequencer
	logic				empty;
	logic				pop;
	pkg_tpu::instr_t		rd_instr;
	pkg_tpu::id_t			rd_thread_id;
	pkg_tpu::issue_no_t		rd_issue_no;

	logic				term;		// Sequencer back to front end

	tpu_front_end i_tpu_front_end (
		.clock(clock), .reset(reset),
		.en_exe(en_exe), .req(req), .word(word), .issue_no(issue_no),
		.almost_full(almost_full), .term(term), .nack(nack),
		.buf_we(buf_we), .buf_instr(buf_instr),
		.buf_thread_id(buf_thread_id), .buf_issue_no(buf_issue_no)
	);

	tpu_instr_buffer #(.BUFFER_DEPTH(BUFFER_DEPTH)) i_tpu_instr_buffer (
		.clock(clock), .reset(reset),
		.we(buf_we), .wr_instr(buf_instr),
		.wr_thread_id(buf_thread_id), .wr_issue_no(buf_issue_no),
		.pop(pop), .empty(empty), .almost_full(almost_full),
		.rd_instr(rd_instr), .rd_thread_id(rd_thread_id), .rd_issue_no(rd_issue_no)
	);

	tpu_scalar_sequencer #(.MUL_CYCLES(MUL_CYCLES)) i_tpu_scalar_sequencer (
		.clock(clock), .reset(reset),
		.empty(empty), .instr(rd_instr),
		.thread_id(rd_thread_id), .issue_no(rd_issue_no),
		.pop(pop), .term(term), .commit_valid(commit_valid),
		.commit_issue_no(commit_issue_no), .commit_thread_id(commit_thread_id),
		.commit_acc(commit_acc)
	);

endmodule

`default_nettype wire

// File: tb_tpu_model.svh
/*
 * Reference model of one thread lane
 * Reads accepted host words and queues the commit each stream must produce
 */
`ifndef TB_TPU_MODEL_SVH
`define TB_TPU_MODEL_SVH

typedef struct packed {
	pkg_tpu::issue_no_t	issue_no;
	pkg_tpu::id_t		thread_id;
	pkg_tpu::acc_t		acc;
} commit_t;

commit_t		expected_q[$];		// Oldest stream first
commit_t		model_ctx;		// Open stream and its running value
int			model_phase = 0;	// 0 header, 1 thread ID, 2 instructions

// ADD and MUL wrap at 32 bits, anything else leaves the value alone
function automatic pkg_tpu::acc_t apply_op(input pkg_tpu::acc_t acc,
		input pkg_tpu::instr_t w);
	logic [63:0] wide;
	wide = {32'h0, acc} * {48'h0, w.operand};
	case (w.op)
		pkg_tpu::OP_ADD: return acc + {16'h0, w.operand};
		pkg_tpu::OP_MUL: return wide[31:0];
		default: return acc;
	endcase
endfunction

task automatic take_word(input pkg_tpu::instr_t w, input pkg_tpu::issue_no_t ino);
	case (model_phase)
		0: begin
			model_ctx.issue_no = ino;		// Header carries the issue number
			model_ctx.acc = '0;
			model_phase = 1;
		end
		1: begin
			model_ctx.thread_id = w.operand[7:0];
			model_phase = 2;
		end
		default: begin
			if (w.op == pkg_tpu::OP_END) begin
				expected_q.push_back(model_ctx);
				model_phase = 0;
			end else begin
				model_ctx.acc = apply_op(model_ctx.acc, w);
			end
		end
	endcase
endtask

`endif

// File: tb_tpu_frontend.sv
/*
 * Testbench for the TPU front-end lane
 * Random host streams with stalls and back-pressure, checked against a model
 */
`timescale 1ns/10ps
`default_nettype none

module tb_tpu_frontend;

	localparam int STREAMS		= 40;
	localparam int WAIT_LIMIT	= 200;		// Cycles per wait loop

	logic			clock;
	logic			reset;
	logic			en_exe;
	logic			req;
	pkg_tpu::instr_t	word;
	pkg_tpu::issue_no_t	issue_no;
	logic			nack;
	logic			commit_valid;
	pkg_tpu::issue_no_t	commit_issue_no;
	pkg_tpu::id_t		commit_thread_id;
	pkg_tpu::acc_t		commit_acc;

	int			errors = 0;
	int			timeouts = 0;
	int			commits = 0;
	int			bp_seen = 0;		// Cycles a stream word sat under nack

	`include "tb_tpu_model.svh"

	tpu_frontend_top #(.BUFFER_DEPTH(8), .MUL_CYCLES(4)) i_tpu_frontend_top (
		.clock(clock), .reset(reset), .en_exe(en_exe), .req(req), .word(word),
		.issue_no(issue_no), .nack(nack), .commit_valid(commit_valid),
		.commit_issue_no(commit_issue_no), .commit_thread_id(commit_thread_id),
		.commit_acc(commit_acc)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp) else begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Host driver
	////////////////////////////////////////////////////////////
	task automatic send_word(input pkg_tpu::instr_t w, input pkg_tpu::issue_no_t ino,
			input bit in_stream, input bit steady);
		int waited;
		int pick;
		bit taken;
		waited = 0;
		taken = 1'b0;
		while (!taken && timeouts == 0) begin
			@(negedge clock);
			pick = steady ? 9 : $urandom_range(0, 9);
			req = (pick != 0);			// Gap
			en_exe = (pick != 1);			// Same word, lane disabled
			word = w;
			issue_no = ino;
			if (pick == 2) begin
				word = {1'b0, pkg_tpu::op_t'(2'($urandom)), 16'($urandom)};
			end
			if (req && en_exe && word.v && !nack) begin
				take_word(word, issue_no);	// Taken at the next rising edge
				taken = 1'b1;
			end else if (nack && in_stream) begin
				bp_seen++;
			end
			waited++;
			if (waited > WAIT_LIMIT) begin
				timeouts++;
				$display("Timed out waiting for the lane to accept a word");
			end
		end
	endtask

	// Stray instructions while nack holds after END, then the bus goes idle
	task automatic wait_ready();
		int waited;
		bit ready;
		waited = 0;
		ready = 1'b0;
		while (!ready && timeouts == 0) begin
			@(negedge clock);
			ready = !nack;
			req = !ready;
			en_exe = 1'b1;
			word = {1'b1, pkg_tpu::OP_ADD, 16'($urandom)};
			waited++;
			if (waited > WAIT_LIMIT) begin
				timeouts++;
				$display("Timed out waiting for the lane to finish a stream");
			end
		end
	endtask

	// Each commit must match the oldest stream the model closed
	always @(negedge clock) begin
		commit_t expected;
		if (!reset && commit_valid) begin
			commits++;
			assert (expected_q.size() > 0) else begin
				errors++;
				$display("A commit arrived with no open stream to close");
			end
			if (expected_q.size() > 0) begin
				expected = expected_q.pop_front();
				check_value("commit_issue_no", commit_issue_no, expected.issue_no);
				check_value("commit_thread_id", commit_thread_id, expected.thread_id);
				check_value("commit_acc", commit_acc, expected.acc);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		int s;
		int i;
		int n;
		bit steady;
		pkg_tpu::instr_t w;
		void'($urandom(60353));
		reset = 1'b1;
		en_exe = 1'b0;
		req = 1'b0;
		word = '0;
		issue_no = '0;
		repeat (16) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		check_value("nack", nack, 32'h0);
		check_value("commit_valid", commit_valid, 32'h0);

		for (s = 0; s < STREAMS && timeouts == 0; s++) begin
			steady = (s % 4 == 3);		// Long MUL run to fill the buffer
			n = steady ? 12 : $urandom_range(1, 12);
			send_word({1'b1, pkg_tpu::OP_NOP, 16'($urandom)}, 4'($urandom), 1'b0, steady);
			send_word({1'b1, pkg_tpu::op_t'(2'($urandom)), 16'($urandom)}, 4'($urandom),
				1'b0, steady);
			for (i = 0; i < n; i++) begin
				w.v = 1'b1;
				w.op = steady ? ((i == 0) ? pkg_tpu::OP_ADD : pkg_tpu::OP_MUL)
					: pkg_tpu::op_t'(2'($urandom_range(0, 2)));
				w.operand = 16'($urandom);
				send_word(w, 4'($urandom), 1'b1, steady);
			end
			send_word({1'b1, pkg_tpu::OP_END, 16'($urandom)}, 4'($urandom), 1'b1, steady);
			wait_ready();
		end

		assert (bp_seen > 0) else begin
			errors++;
			$display("Back-pressure never raised nack during a stream");
		end
		assert (expected_q.size() == 0) else begin
			errors++;
			$display("Some streams ended without a commit");
		end
		$display("Errors: %0d, timeouts: %0d, commits: %0d", errors, timeouts, commits);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tpu_frontend.f
pkg_tpu.sv
tpu_front_end.sv
tpu_instr_buffer.sv
tpu_scalar_sequencer.sv
tpu_frontend_top.sv
+incdir+.
tb_tpu_frontend.sv

// File: run_sim.sh
#!/bin/sh
# Builds the TPU front-end lane with Verilator and runs its testbench
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_tpu_frontend \
	-f tpu_frontend.f \
	-o sim_tpu_frontend

./obj_dir/sim_tpu_frontend > "$LOG" 2>&1
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
	echo "Testbench reported a failure, see $LOG"
	exit 1
fi

echo "Testbench run complete, see $LOG"
exit 0
